// File: ninjin_tests.txt
# p <byte addr> <word> preloads one model memory word
# e <word> is one expected W beat for the next write, in beat order
# o <mode 0 rd 1 wr> <byte base> <ram base> <len> <fault> <fault beat> <retrig> <exp err>
p 40 3f8a0011
p 44 71c2e4a9
p 48 00000000
p 4c ffffffff
p 50 a5a55a5a
p 54 12345678
p 100 deadbeef
p 104 0badf00d
p 108 5eed9606
o 0 40 10 6 0 0 0 0
e 3f8a0011
e 71c2e4a9
e 00000000
e ffffffff
e a5a55a5a
e 12345678
o 1 40 10 6 0 0 0 0
o 0 100 40 3 1 1 1 3
e deadbeef
e 0badf00d
e 5eed9606
o 1 100 40 3 1 0 1 5
o 0 200 80 1 0 0 0 0
e c0de0080
o 1 200 80 1 0 0 0 0

// File: ninjin.f
ninjin_pkg.sv
ninjin_req_decode.sv
ninjin_axi_read.sv
ninjin_axi_write.sv
ninjin_image_ram.sv
ninjin_status.sv
ninjin_dma_top.sv
ninjin_axi_mem_model.sv
ninjin_dma_tb.sv

// File: ninjin_dma_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_dma_tb;

  import ninjin_pkg::*;

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;
  localparam int MEM_AW     = 10;
  localparam int WAIT_LIMIT = 2000;

  logic                  clk;
  logic                  xrst;
  logic                  ddr_req;
  logic                  ddr_mode;
  logic [MEM_AW-1:0]     ddr_base;
  logic [MEM_AW-1:0]     ddr_len;
  logic [2:0]            err;
  logic                  busy_read;
  logic                  busy_write;
  logic                  done_read;
  logic                  done_write;
  logic [ADDR_WIDTH-1:0] araddr;
  logic [7:0]            arlen;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic [7:0]            awlen;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic                  fault_rd;
  logic                  fault_wr;
  logic [7:0]            fault_beat;

  int                    value_errors = 0;
  int                    other_errors = 0;
  logic                  aborted = 1'b0;

  // captured on the AXI side by the monitor
  int                    ar_count;
  int                    aw_count;
  int                    r_beats;
  int                    done_rd_count;
  int                    done_wr_count;
  logic [ADDR_WIDTH-1:0] ar_addr;
  logic [7:0]            ar_len;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic [7:0]            aw_len;
  logic [DATA_WIDTH-1:0] wdata_q[$];
  logic                  wlast_q[$];
  logic [DATA_WIDTH-1:0] exp_q[$];

  ninjin_dma_top #(
    .BURST_MAX(256), .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH), .MEM_ADDR_WIDTH(MEM_AW)
  ) UUT (
    .clk, .xrst, .ddr_req, .ddr_mode, .ddr_base, .ddr_len,
    .err, .busy_read, .busy_write, .done_read, .done_write,
    .araddr, .arlen, .arvalid, .arready, .rdata, .rresp, .rlast, .rvalid, .rready,
    .awaddr, .awlen, .awvalid, .awready, .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

  ninjin_axi_mem_model #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .WORD_AW(MEM_AW)
  ) mem_model (
    .clk, .xrst, .fault_rd, .fault_beat, .fault_wr,
    .araddr, .arlen, .arvalid, .arready, .rdata, .rresp, .rlast, .rvalid, .rready,
    .awaddr, .awvalid, .awready, .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

  always #2 clk = ~clk;

  // handshakes sampled at mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (arvalid && arready) begin
      ar_count++;
      ar_addr = araddr;
      ar_len  = arlen;
    end
    if (awvalid && awready) begin
      aw_count++;
      aw_addr = awaddr;
      aw_len  = awlen;
    end
    if (rvalid && rready) begin
      r_beats++;
    end
    if (wvalid && wready) begin
      wdata_q.push_back(wdata);
      wlast_q.push_back(wlast);
    end
    if (done_read) begin
      done_rd_count++;
    end
    if (done_write) begin
      done_wr_count++;
    end
  end

  // ==============================
  // compare tasks
  // ==============================
  task automatic err_check(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("** Error: err got 0x%h expected 0x%h at %0t", got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic word_check(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic addr_check(input string name, input logic [ADDR_WIDTH-1:0] got,
                            input logic [ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic len_check(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic count_check(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic idle_check();
    bit_check("arvalid", arvalid, 1'b0);
    bit_check("rready", rready, 1'b0);
    bit_check("awvalid", awvalid, 1'b0);
    bit_check("wvalid", wvalid, 1'b0);
    bit_check("bready", bready, 1'b0);
    bit_check("busy_read", busy_read, 1'b0);
    bit_check("busy_write", busy_write, 1'b0);
    bit_check("done_read", done_read, 1'b0);
    bit_check("done_write", done_write, 1'b0);
    err_check(err, 3'b000);
  endtask

  // ==============================
  // one host operation
  // ==============================
  task automatic run_op(input logic op_mode, input logic [ADDR_WIDTH-1:0] byte_base,
                        input logic [MEM_AW-1:0] ram_base, input logic [MEM_AW-1:0] len,
                        input logic fault, input logic [7:0] beat, input logic retrig,
                        input logic [2:0] exp_err);
    int   cycles;
    int   i;
    logic seen_busy;
    logic got_done;
    logic busy_now;
    @(posedge clk);
    ddr_req    <= 1'b1;
    ddr_mode   <= op_mode;
    ddr_base   <= ram_base;
    ddr_len    <= len;
    fault_rd   <= fault && (op_mode == DDR_READ);
    fault_wr   <= fault && (op_mode == DDR_WRITE);
    fault_beat <= beat;
    ar_count      = 0;
    aw_count      = 0;
    r_beats       = 0;
    done_rd_count = 0;
    done_wr_count = 0;
    wdata_q.delete();
    wlast_q.delete();
    @(posedge clk);
    ddr_req <= 1'b0;
    if (retrig) begin
      // second edge arrives while the direction is busy
      @(posedge clk);
      ddr_req <= 1'b1;
      @(posedge clk);
      ddr_req <= 1'b0;
    end
    cycles    = 0;
    seen_busy = 1'b0;
    got_done  = 1'b0;
    busy_now  = 1'b0;
    while (!got_done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      busy_now = (op_mode == DDR_READ) ? busy_read : busy_write;
      got_done = (op_mode == DDR_READ) ? done_read : done_write;
      if (busy_now && !seen_busy) begin
        seen_busy = 1'b1;
        err_check(err, 3'b000);
      end
    end
    if (!got_done) begin
      $display("timeout: no done pulse for the %s at 0x%h within %0d cycles",
               (op_mode == DDR_READ) ? "read" : "write", byte_base, WAIT_LIMIT);
      other_errors++;
      aborted = 1'b1;
      return;
    end
    if (!seen_busy) begin
      $display("busy flag never rose during the operation at 0x%h", byte_base);
      other_errors++;
    end
    // busy falls in the same cycle as done
    bit_check("busy", busy_now, 1'b0);
    err_check(err, exp_err);
    @(negedge clk);
    bit_check("done", (op_mode == DDR_READ) ? done_read : done_write, 1'b0);
    @(posedge clk);
    if (op_mode == DDR_READ) begin
      count_check("AR handshakes", ar_count, 1);
      addr_check("araddr", ar_addr, byte_base);
      len_check("arlen", ar_len, 8'(len - 1'b1));
      count_check("R beats", r_beats, len);
      count_check("done_read pulses", done_rd_count, 1);
    end else begin
      count_check("AW handshakes", aw_count, 1);
      addr_check("awaddr", aw_addr, byte_base);
      len_check("awlen", aw_len, 8'(len - 1'b1));
      count_check("W beats", wdata_q.size(), len);
      count_check("done_write pulses", done_wr_count, 1);
      if (exp_q.size() != len) begin
        $display("test file gives %0d expected words for a write of %0d beats",
                 exp_q.size(), len);
        other_errors++;
      end
      for (i = 0; i < wdata_q.size() && i < exp_q.size(); i++) begin
        word_check("wdata", wdata_q[i], exp_q[i]);
        bit_check("wlast", wlast_q[i], i == len - 1);
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int                    fd;
    int                    n;
    int                    ops_run;
    string                 line;
    logic [31:0]           f_mode;
    logic [31:0]           f_bbase;
    logic [31:0]           f_rbase;
    logic [31:0]           f_len;
    logic [31:0]           f_fault;
    logic [31:0]           f_beat;
    logic [31:0]           f_retrig;
    logic [31:0]           f_err;
    logic [31:0]           f_addr;
    logic [DATA_WIDTH-1:0] f_word;
    clk        = 1'b0;
    xrst       = 1'b0;
    ddr_req    = 1'b0;
    ddr_mode   = 1'b0;
    ddr_base   = '0;
    ddr_len    = '0;
    fault_rd   = 1'b0;
    fault_wr   = 1'b0;
    fault_beat = '0;
    ops_run    = 0;
    repeat (5) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    idle_check();
    fd = $fopen("ninjin_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open ninjin_tests.txt");
      other_errors++;
    end else begin
      while (!aborted && !$feof(fd)) begin
        if ($fgets(line, fd) == 0) begin
          break;
        end
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        case (line[0])
          "p": begin
            n = $sscanf(line, "p %h %h", f_addr, f_word);
            mem_model.mem[f_addr >> 2] = f_word;
          end
          "e": begin
            n = $sscanf(line, "e %h", f_word);
            exp_q.push_back(f_word);
          end
          "o": begin
            n = $sscanf(line, "o %h %h %h %h %h %h %h %h", f_mode, f_bbase, f_rbase,
                        f_len, f_fault, f_beat, f_retrig, f_err);
            if (n != 8) begin
              $display("malformed operation line in test file: %s", line);
              other_errors++;
            end else begin
              run_op(f_mode[0], f_bbase, f_rbase[MEM_AW-1:0], f_len[MEM_AW-1:0],
                     f_fault[0], f_beat[7:0], f_retrig[0], f_err[2:0]);
              ops_run++;
            end
            exp_q.delete();
          end
          default: begin
            $display("unknown line kind in test file: %s", line);
            other_errors++;
          end
        endcase
      end
      $fclose(fd);
      if (ops_run == 0) begin
        $display("test file held no operations");
        other_errors++;
      end
    end
    $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ninjin_axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_axi_mem_model #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 32,
  parameter int WORD_AW    = 10
) (
  input  logic                  clk,
  input  logic                  xrst,
  // error injection from the testbench
  input  logic                  fault_rd,
  input  logic [7:0]            fault_beat,
  input  logic                  fault_wr,
  // read channels
  input  logic [ADDR_WIDTH-1:0] araddr,
  input  logic [7:0]            arlen,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rlast,
  output logic                  rvalid,
  input  logic                  rready,
  // write channels
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  wlast,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready
);

  import ninjin_pkg::*;

  localparam int BYTE_SHIFT = clogb2(DATA_WIDTH / 8 - 1);

  logic [DATA_WIDTH-1:0] mem [0:2**WORD_AW-1];
  int                    seed = 32'h9606;
  logic                  r_busy;
  logic [WORD_AW-1:0]    r_base;
  logic [7:0]            r_len;
  logic [7:0]            r_idx;
  logic                  w_busy;
  logic                  b_pend;
  logic [WORD_AW-1:0]    w_base;
  logic [7:0]            w_idx;

  // every word differs so a wrong address shows up in the data
  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    r_busy  = 1'b0;
    r_base  = '0;
    r_len   = '0;
    r_idx   = '0;
    w_busy  = 1'b0;
    b_pend  = 1'b0;
    w_base  = '0;
    w_idx   = '0;
    for (int i = 0; i < 2**WORD_AW; i++) begin
      mem[i] = DATA_WIDTH'(32'hc0de0000 + i);
    end
  end

  // R payload follows the beat index and holds while rvalid waits
  assign rdata = mem[r_base + WORD_AW'(r_idx)];
  assign rlast = (r_idx == r_len);
  assign rresp = (fault_rd && (r_idx == fault_beat)) ? RESP_SLVERR : RESP_OKAY;
  assign bresp = fault_wr ? RESP_SLVERR : RESP_OKAY;

  always @(posedge clk) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (!xrst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      r_busy  <= 1'b0;
      w_busy  <= 1'b0;
      b_pend  <= 1'b0;
    end else begin
      // ==============================
      // read side
      // ==============================
      if (arvalid && arready) begin
        arready <= 1'b0;
        r_busy  <= 1'b1;
        r_base  <= araddr[WORD_AW+BYTE_SHIFT-1:BYTE_SHIFT];
        r_len   <= arlen;
        r_idx   <= '0;
      end else begin
        arready <= !r_busy && rnd[0];
      end
      if (rvalid && rready) begin
        r_idx <= r_idx + 1'b1;
        if (rlast) begin
          r_busy <= 1'b0;
        end
      end
      if (!r_busy || (rvalid && rready && rlast)) begin
        rvalid <= 1'b0;
      end else if (!rvalid || rready) begin
        rvalid <= rnd[1] | rnd[2];
      end
      // ==============================
      // write side
      // ==============================
      if (awvalid && awready) begin
        awready <= 1'b0;
        w_busy  <= 1'b1;
        w_base  <= awaddr[WORD_AW+BYTE_SHIFT-1:BYTE_SHIFT];
        w_idx   <= '0;
      end else begin
        awready <= !w_busy && rnd[6];
      end
      if (wvalid && wready) begin
        mem[w_base + WORD_AW'(w_idx)] <= wdata;
        w_idx <= w_idx + 1'b1;
        if (wlast) begin
          b_pend <= 1'b1;
        end
      end
      wready <= w_busy && !b_pend && !(wvalid && wready && wlast) && rnd[3];
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_pend <= 1'b0;
        w_busy <= 1'b0;
      end else if (b_pend && !bvalid) begin
        bvalid <= rnd[5];
      end
    end
  end

endmodule

`default_nettype wire

// File: ninjin_dma_top.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_dma_top #(
  parameter int BURST_MAX      = 256,
  parameter int DATA_WIDTH     = 32,
  parameter int ADDR_WIDTH     = 32,
  parameter int MEM_ADDR_WIDTH = 10
) (
  input  logic                      clk,
  input  logic                      xrst,
  // host side
  input  logic                      ddr_req,
  input  logic                      ddr_mode,
  input  logic [MEM_ADDR_WIDTH-1:0] ddr_base,
  input  logic [MEM_ADDR_WIDTH-1:0] ddr_len,
  output logic [2:0]                err,
  output logic                      busy_read,
  output logic                      busy_write,
  output logic                      done_read,
  output logic                      done_write,
  // axi read channels
  output logic [ADDR_WIDTH-1:0]     araddr,
  output logic [7:0]                arlen,
  output logic                      arvalid,
  input  logic                      arready,
  input  logic [DATA_WIDTH-1:0]     rdata,
  input  logic [1:0]                rresp,
  input  logic                      rlast,
  input  logic                      rvalid,
  output logic                      rready,
  // axi write channels
  output logic [ADDR_WIDTH-1:0]     awaddr,
  output logic [7:0]                awlen,
  output logic                      awvalid,
  input  logic                      awready,
  output logic [DATA_WIDTH-1:0]     wdata,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      bready
);

  import ninjin_pkg::*;

  // beat index width, 8 bits for a 256 beat burst
  localparam int IDX_WIDTH = clogb2(BURST_MAX - 1);

  logic                      rd_start;
  logic                      wr_start;
  logic [MEM_ADDR_WIDTH-1:0] rd_base;
  logic [MEM_ADDR_WIDTH-1:0] rd_len;
  logic [MEM_ADDR_WIDTH-1:0] wr_base;
  logic [MEM_ADDR_WIDTH-1:0] wr_len;
  logic                      rd_end;
  logic                      wr_end;
  logic                      rd_err_beat;
  logic                      wr_err_resp;
  logic                      ram_we;
  logic [MEM_ADDR_WIDTH-1:0] ram_waddr;
  logic [DATA_WIDTH-1:0]     ram_wdata;
  logic [MEM_ADDR_WIDTH-1:0] ram_raddr;
  logic [DATA_WIDTH-1:0]     ram_rdata;

  ninjin_req_decode #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_decode (
    .clk, .xrst, .ddr_req, .ddr_mode, .ddr_base, .ddr_len,
    .busy_read, .busy_write, .rd_start, .wr_start,
    .rd_base, .rd_len, .wr_base, .wr_len
  );

  ninjin_axi_read #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH), .IDX_WIDTH(IDX_WIDTH)
  ) u_read (
    .clk, .xrst, .rd_start, .rd_base, .rd_len,
    .araddr, .arlen, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .ram_we, .ram_waddr, .ram_wdata, .rd_end, .rd_err_beat
  );

  ninjin_axi_write #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH), .IDX_WIDTH(IDX_WIDTH)
  ) u_write (
    .clk, .xrst, .wr_start, .wr_base, .wr_len,
    .awaddr, .awlen, .awvalid, .awready,
    .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .ram_raddr, .ram_rdata, .wr_end, .wr_err_resp
  );

  ninjin_image_ram #(
    .DATA_WIDTH(DATA_WIDTH), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) u_ram (
    .clk, .ram_we, .ram_waddr, .ram_wdata, .ram_raddr, .ram_rdata
  );

  ninjin_status u_status (
    .clk, .xrst, .rd_start, .wr_start, .rd_end, .wr_end,
    .rd_err_beat, .wr_err_resp,
    .err, .busy_read, .busy_write, .done_read, .done_write
  );

endmodule

`default_nettype wire

// File: ninjin_status.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_status (
  input  logic       clk,
  input  logic       xrst,
  input  logic       rd_start,
  input  logic       wr_start,
  input  logic       rd_end,
  input  logic       wr_end,
  input  logic       rd_err_beat,
  input  logic       wr_err_resp,
  output logic [2:0] err,
  output logic       busy_read,
  output logic       busy_write,
  output logic       done_read,
  output logic       done_write
);

  import ninjin_pkg::*;

  // busy drops in the same cycle the done pulse appears
  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy_read  <= 1'b0;
      busy_write <= 1'b0;
      done_read  <= 1'b0;
      done_write <= 1'b0;
    end else begin
      done_read  <= rd_end;
      done_write <= wr_end;
      if (rd_start) begin
        busy_read <= 1'b1;
      end else if (rd_end) begin
        busy_read <= 1'b0;
      end
      if (wr_start) begin
        busy_write <= 1'b1;
      end else if (wr_end) begin
        busy_write <= 1'b0;
      end
    end
  end

  // sticky error flags, cleared by any new operation
  always_ff @(posedge clk) begin
    if (!xrst) begin
      err <= '0;
    end else if (rd_start || wr_start) begin
      err <= '0;
    end else begin
      if (rd_err_beat) begin
        err[ERR_RRESP] <= 1'b1;
        err[ERR_ANY]   <= 1'b1;
      end
      if (wr_err_resp) begin
        err[ERR_WRESP] <= 1'b1;
        err[ERR_ANY]   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: ninjin_image_ram.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_image_ram #(
  parameter int DATA_WIDTH     = 32,
  parameter int MEM_ADDR_WIDTH = 10
) (
  input  logic                      clk,
  input  logic                      ram_we,
  input  logic [MEM_ADDR_WIDTH-1:0] ram_waddr,
  input  logic [DATA_WIDTH-1:0]     ram_wdata,
  input  logic [MEM_ADDR_WIDTH-1:0] ram_raddr,
  output logic [DATA_WIDTH-1:0]     ram_rdata
);

  logic [DATA_WIDTH-1:0] mem [0:2**MEM_ADDR_WIDTH-1];

  // port a writes, port b reads with one cycle latency
  always_ff @(posedge clk) begin
    if (ram_we) begin
      mem[ram_waddr] <= ram_wdata;
    end
    ram_rdata <= mem[ram_raddr];
  end

endmodule

`default_nettype wire

// File: ninjin_axi_write.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_axi_write #(
  parameter int DATA_WIDTH     = 32,
  parameter int ADDR_WIDTH     = 32,
  parameter int MEM_ADDR_WIDTH = 10,
  parameter int IDX_WIDTH      = 8
) (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      wr_start,
  input  logic [MEM_ADDR_WIDTH-1:0] wr_base,
  input  logic [MEM_ADDR_WIDTH-1:0] wr_len,
  output logic [ADDR_WIDTH-1:0]     awaddr,
  output logic [7:0]                awlen,
  output logic                      awvalid,
  input  logic                      awready,
  output logic [DATA_WIDTH-1:0]     wdata,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      bready,
  output logic [MEM_ADDR_WIDTH-1:0] ram_raddr,
  input  logic [DATA_WIDTH-1:0]     ram_rdata,
  output logic                      wr_end,
  output logic                      wr_err_resp
);

  import ninjin_pkg::*;

  localparam int BYTE_SHIFT = clogb2(DATA_WIDTH / 8 - 1);

  logic                      aw_hs;
  logic                      w_hs;
  logic                      b_hs;
  logic                      prefetch;
  logic [MEM_ADDR_WIDTH-1:0] len_m1;
  logic [IDX_WIDTH-1:0]      beat_idx;
  logic [IDX_WIDTH-1:0]      last_idx;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;

  // ==============================
  // write address
  // ==============================
  assign len_m1 = wr_len - 1'b1;
  assign awaddr = ADDR_WIDTH'(wr_base) << BYTE_SHIFT;
  assign awlen  = len_m1[7:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awvalid <= 1'b0;
    end else if (wr_start) begin
      awvalid <= 1'b1;
    end else if (aw_hs) begin
      awvalid <= 1'b0;
    end
  end

  // ==============================
  // write data
  // ==============================
  // ram read port has one cycle latency, so the first word needs
  // one prefetch cycle before wvalid
  assign last_idx = len_m1[IDX_WIDTH-1:0];
  assign wdata    = ram_rdata;
  assign wlast    = wvalid && (beat_idx == last_idx);

  // next word only once the current beat is taken,
  // a stalled beat keeps rereading its own word
  assign ram_raddr = wr_base + MEM_ADDR_WIDTH'(beat_idx) + MEM_ADDR_WIDTH'(w_hs);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prefetch <= 1'b0;
      wvalid   <= 1'b0;
    end else begin
      prefetch <= aw_hs;
      if (prefetch) begin
        wvalid <= 1'b1;
      end else if (w_hs && wlast) begin
        wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      beat_idx <= '0;
    end else if (wr_start) begin
      beat_idx <= '0;
    end else if (w_hs) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  // ==============================
  // write response
  // ==============================
  assign wr_end      = b_hs;
  assign wr_err_resp = b_hs && bresp[1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bready <= 1'b0;
    end else if (w_hs && wlast) begin
      bready <= 1'b1;
    end else if (b_hs) begin
      bready <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: ninjin_axi_read.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_axi_read #(
  parameter int DATA_WIDTH     = 32,
  parameter int ADDR_WIDTH     = 32,
  parameter int MEM_ADDR_WIDTH = 10,
  parameter int IDX_WIDTH      = 8
) (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      rd_start,
  input  logic [MEM_ADDR_WIDTH-1:0] rd_base,
  input  logic [MEM_ADDR_WIDTH-1:0] rd_len,
  output logic [ADDR_WIDTH-1:0]     araddr,
  output logic [7:0]                arlen,
  output logic                      arvalid,
  input  logic                      arready,
  input  logic [DATA_WIDTH-1:0]     rdata,
  input  logic [1:0]                rresp,
  input  logic                      rlast,
  input  logic                      rvalid,
  output logic                      rready,
  output logic                      ram_we,
  output logic [MEM_ADDR_WIDTH-1:0] ram_waddr,
  output logic [DATA_WIDTH-1:0]     ram_wdata,
  output logic                      rd_end,
  output logic                      rd_err_beat
);

  import ninjin_pkg::*;

  localparam int BYTE_SHIFT = clogb2(DATA_WIDTH / 8 - 1);

  logic                      ar_hs;
  logic                      r_hs;
  logic [MEM_ADDR_WIDTH-1:0] len_m1;
  logic [IDX_WIDTH-1:0]      beat_idx;

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;

  // ==============================
  // read address
  // ==============================
  assign len_m1 = rd_len - 1'b1;
  assign araddr = ADDR_WIDTH'(rd_base) << BYTE_SHIFT;
  assign arlen  = len_m1[7:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      if (rd_start) begin
        arvalid <= 1'b1;
      end else if (ar_hs) begin
        arvalid <= 1'b0;
      end
      // never back-pressure R inside the burst
      if (ar_hs) begin
        rready <= 1'b1;
      end else if (r_hs && rlast) begin
        rready <= 1'b0;
      end
    end
  end

  // ==============================
  // read data into image ram
  // ==============================
  assign rd_end      = r_hs && rlast;
  assign rd_err_beat = r_hs && rresp[1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      beat_idx <= '0;
      ram_we   <= 1'b0;
    end else begin
      ram_we <= r_hs;
      if (rd_start) begin
        beat_idx <= '0;
      end else if (r_hs) begin
        beat_idx <= beat_idx + 1'b1;
      end
    end
  end

  // beat i lands at rd_base + i one cycle later
  always_ff @(posedge clk) begin
    ram_waddr <= rd_base + MEM_ADDR_WIDTH'(beat_idx);
    ram_wdata <= rdata;
  end

endmodule

`default_nettype wire

// File: ninjin_req_decode.sv
`timescale 1ns/100ps
`default_nettype none

module ninjin_req_decode #(
  parameter int MEM_ADDR_WIDTH = 10
) (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      ddr_req,
  input  logic                      ddr_mode,
  input  logic [MEM_ADDR_WIDTH-1:0] ddr_base,
  input  logic [MEM_ADDR_WIDTH-1:0] ddr_len,
  input  logic                      busy_read,
  input  logic                      busy_write,
  output logic                      rd_start,
  output logic                      wr_start,
  output logic [MEM_ADDR_WIDTH-1:0] rd_base,
  output logic [MEM_ADDR_WIDTH-1:0] rd_len,
  output logic [MEM_ADDR_WIDTH-1:0] wr_base,
  output logic [MEM_ADDR_WIDTH-1:0] wr_len
);

  import ninjin_pkg::*;

  logic req_d;
  logic req_edge;
  logic rd_accept;
  logic wr_accept;

  assign req_edge  = ddr_req && !req_d;
  // an edge into a busy direction is dropped
  assign rd_accept = req_edge && (ddr_mode == DDR_READ) && !busy_read;
  assign wr_accept = req_edge && (ddr_mode == DDR_WRITE) && !busy_write;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_d    <= 1'b0;
      rd_start <= 1'b0;
      wr_start <= 1'b0;
    end else begin
      req_d    <= ddr_req;
      rd_start <= rd_accept;
      wr_start <= wr_accept;
    end
  end

  // per-direction request, held until the next accepted edge
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_base <= ddr_base;
      rd_len  <= ddr_len;
    end
    if (wr_accept) begin
      wr_base <= ddr_base;
      wr_len  <= ddr_len;
    end
  end

endmodule

`default_nettype wire

// File: ninjin_pkg.sv
`default_nettype none

package ninjin_pkg;

  // ==============================
  // host request direction
  // ==============================
  localparam logic DDR_READ  = 1'b0;
  localparam logic DDR_WRITE = 1'b1;

  // ==============================
  // axi response codes
  // ==============================
  // bit 1 set means the slave flagged an error
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // bit positions in the err word
  localparam int ERR_ANY   = 0;
  localparam int ERR_RRESP = 1;
  localparam int ERR_WRESP = 2;

  // bits needed to hold value, e.g. 255 -> 8
  function automatic int clogb2(input int value);
    int v;
    int n;
    v = value;
    n = 0;
    while (v > 0) begin
      n = n + 1;
      v = v >> 1;
    end
    return n;
  endfunction

endpackage

`default_nettype wire
